/* include/loader_settings.svh */
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// ============================================================
// Memory geometry
// ============================================================

// External byte memory address width
`define ADDR_W 25

// Width of one data byte
`define DATA_W 8

// ============================================================
// Load regions
// ============================================================

// First address of cartridge chip data
`define CRT_BASE 25'h100000

// First address of the stored tape image
`define TAP_BASE 25'h200000

// ============================================================
// CRT file layout
// ============================================================

// File offset of the cartridge id, followed by EXROM and GAME
`define CRT_HDR_ID 'h16

// File offset of the first chip packet
`define CRT_CHIP_START 'h40

// Chip packet header length, counted inside the packet length
`define CHIP_HDR_LEN 16

// Chip data lands on 8 KB boundaries
`define BANK_ALIGN_W 13

// ============================================================
// Erase
// ============================================================

// Last address written by a memory erase
`define ERASE_TOP 'hFFFF

`endif

/* logic/loader_pkg.sv */
`include "loader_settings.svh"

package loader_pkg;

	// Memory address and data byte
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`DATA_W-1:0] byte_t;

	// File kind of the running download
	typedef enum logic [1:0] {
		LOAD_NONE,
		LOAD_PRG,
		LOAD_CRT,
		LOAD_TAP
	} load_kind_e;

	// Where the CRT parser stands inside the file
	typedef enum logic [1:0] {
		CRT_FILE_HDR,
		CRT_CHIP_HDR,
		CRT_CHIP_DATA
	} crt_state_e;

	// Host index byte to file kind
	function automatic load_kind_e index_to_kind(input byte_t index);
		case (index)
			8'd4: return LOAD_PRG;
			8'd5: return LOAD_CRT;
			8'd6: return LOAD_TAP;
			default: return LOAD_NONE;
		endcase
	endfunction

endpackage

/* logic/mem_pkg.sv */
`include "loader_settings.svh"

package mem_pkg;

	// One operation per memory slot window
	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_LOAD_WR,
		MEM_ERASE_WR,
		MEM_TAP_RD
	} mem_op_e;

	// Erase engine
	typedef enum logic {
		ERASE_IDLE,
		ERASE_RUN
	} seq_state_e;

endpackage

/* logic/load_decode.sv */
`timescale 1ns/100ps
`include "loader_settings.svh"

module load_decode import loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset_n,
	input  logic        dl_active_i,
	input  byte_t       dl_index_i,
	input  logic        dl_wr_i,
	input  addr_t       dl_addr_i,
	input  byte_t       dl_data_i,
	input  logic        detach_i,
	input  logic        wr_ack_i,
	output logic        wr_req_o,
	output addr_t       wr_addr_o,
	output byte_t       wr_data_o,
	output addr_t       tap_len_o,
	output logic        tap_done_o,
	output logic [15:0] cart_id_o,
	output byte_t       cart_exrom_o,
	output byte_t       cart_game_o,
	output logic [15:0] bank_num_o,
	output logic [15:0] bank_laddr_o,
	output logic [15:0] bank_size_o,
	output logic        bank_wr_o,
	output logic        cart_attached_o
);

	load_kind_e load_kind;
	crt_state_e crt_state;
	addr_t      load_addr;
	logic [3:0] hdr_cnt;
	logic [31:0] blk_len;
	logic       dl_active_d;
	logic       dl_end;
	logic       chip_area;
	logic       pkt_start;

	assign load_kind = index_to_kind(dl_index_i);
	assign dl_end    = dl_active_d & ~dl_active_i;
	assign chip_area = dl_addr_i >= addr_t'(`CRT_CHIP_START);
	// Next byte opens a chip packet once the previous data is used up
	assign pkt_start = (crt_state == CRT_FILE_HDR) ||
		((crt_state == CRT_CHIP_DATA) && (blk_len == '0));
	assign wr_addr_o = load_addr;

	// ============================================================
	// Load address, write request and CRT parse state
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dl_active_d <= 1'b0;
			wr_req_o <= 1'b0;
			load_addr <= '0;
			crt_state <= CRT_FILE_HDR;
			hdr_cnt <= '0;
			blk_len <= '0;
			bank_wr_o <= 1'b0;
			tap_len_o <= '0;
			tap_done_o <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			dl_active_d <= dl_active_i;
			bank_wr_o <= 1'b0;
			tap_done_o <= dl_end && (load_kind == LOAD_TAP);

			if (wr_ack_i) begin
				wr_req_o <= 1'b0;
				load_addr <= load_addr + 1'b1;
			end

			if (dl_wr_i) begin
				case (load_kind)
					LOAD_PRG: begin
						// Load address comes first, low byte first
						if (dl_addr_i == '0)
							load_addr <= addr_t'(dl_data_i);
						else if (dl_addr_i == addr_t'(1))
							load_addr[15:8] <= dl_data_i;
						else
							wr_req_o <= 1'b1;
					end
					LOAD_CRT: begin
						if (dl_addr_i == '0) begin
							load_addr <= `CRT_BASE;
							crt_state <= CRT_FILE_HDR;
							hdr_cnt <= '0;
							blk_len <= '0;
						end else if (chip_area) begin
							if (crt_state == CRT_CHIP_HDR) begin
								hdr_cnt <= hdr_cnt + 1'b1;
								// Packet length is big-endian and includes the header
								if (hdr_cnt == 4'd7)
									blk_len <= {blk_len[23:0], dl_data_i} - 32'(`CHIP_HDR_LEN);
								else if (hdr_cnt >= 4'd4 && hdr_cnt < 4'd7)
									blk_len <= {blk_len[23:0], dl_data_i};
								if (hdr_cnt == 4'(`CHIP_HDR_LEN - 1)) begin
									crt_state <= CRT_CHIP_DATA;
									bank_wr_o <= 1'b1;
								end
							end else if (pkt_start) begin
								crt_state <= CRT_CHIP_HDR;
								hdr_cnt <= 4'd1;
								// Round up to the next 8 KB boundary
								if (load_addr[`BANK_ALIGN_W-1:0] != '0)
									load_addr <= {load_addr[`ADDR_W-1:`BANK_ALIGN_W] + 1'b1,
										{`BANK_ALIGN_W{1'b0}}};
							end else begin
								blk_len <= blk_len - 1'b1;
								wr_req_o <= 1'b1;
							end
						end
					end
					LOAD_TAP: begin
						wr_req_o <= 1'b1;
						if (dl_addr_i == '0) begin
							load_addr <= `TAP_BASE;
							tap_len_o <= addr_t'(1);
						end else begin
							tap_len_o <= tap_len_o + 1'b1;
						end
					end
					default: ;
				endcase
			end

			if (detach_i)
				cart_attached_o <= 1'b0;
			else if (dl_end && (load_kind == LOAD_CRT))
				cart_attached_o <= 1'b1;
		end
	end

	// Data byte and cartridge header fields
	always_ff @(posedge clk_sys) begin
		if (dl_wr_i) begin
			wr_data_o <= dl_data_i;
			if (load_kind == LOAD_CRT) begin
				if (dl_addr_i == addr_t'(`CRT_HDR_ID))
					cart_id_o[15:8] <= dl_data_i;
				if (dl_addr_i == addr_t'(`CRT_HDR_ID + 1))
					cart_id_o[7:0] <= dl_data_i;
				if (dl_addr_i == addr_t'(`CRT_HDR_ID + 2))
					cart_exrom_o <= dl_data_i;
				if (dl_addr_i == addr_t'(`CRT_HDR_ID + 3))
					cart_game_o <= dl_data_i;
				if (chip_area && (crt_state == CRT_CHIP_HDR)) begin
					case (hdr_cnt)
						4'd10: bank_num_o[15:8] <= dl_data_i;
						4'd11: bank_num_o[7:0] <= dl_data_i;
						4'd12: bank_laddr_o[15:8] <= dl_data_i;
						4'd13: bank_laddr_o[7:0] <= dl_data_i;
						4'd14: bank_size_o[15:8] <= dl_data_i;
						4'd15: bank_size_o[7:0] <= dl_data_i;
						default: ;
					endcase
				end
			end
		end
	end

endmodule

/* logic/slot_sequencer.sv */
`timescale 1ns/100ps
`include "loader_settings.svh"

module slot_sequencer import loader_pkg::*, mem_pkg::*; (
	input  logic  clk_sys,
	input  logic  reset_n,
	input  logic  slot_i,
	input  logic  wr_req_i,
	input  addr_t wr_addr_i,
	input  byte_t wr_data_i,
	output logic  wr_ack_o,
	input  logic  rd_req_i,
	input  addr_t rd_addr_i,
	output logic  rd_ack_o,
	input  logic  tap_full_i,
	input  logic  erase_start_i,
	output logic  erasing_o,
	output logic  mem_ce_o,
	output logic  mem_we_o,
	output addr_t mem_addr_o,
	output byte_t mem_wdata_o
);

	logic       slot_d;
	logic       slot_fall;
	mem_op_e    op_sel;
	seq_state_e erase_state;
	addr_t      erase_addr;

	// A falling slot edge opens the window for one access
	assign slot_fall = slot_d & ~slot_i;
	assign erasing_o = (erase_state == ERASE_RUN);

	// ============================================================
	// Slot arbitration
	// ============================================================

	// Load write first, then erase, then tape read when the FIFO has room
	always_comb begin
		if (wr_req_i)
			op_sel = MEM_LOAD_WR;
		else if (erase_state == ERASE_RUN)
			op_sel = MEM_ERASE_WR;
		else if (rd_req_i && !tap_full_i)
			op_sel = MEM_TAP_RD;
		else
			op_sel = MEM_IDLE;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_d <= 1'b0;
			mem_ce_o <= 1'b0;
			wr_ack_o <= 1'b0;
			rd_ack_o <= 1'b0;
			erase_state <= ERASE_IDLE;
			erase_addr <= '0;
		end else begin
			slot_d <= slot_i;
			mem_ce_o <= 1'b0;
			wr_ack_o <= 1'b0;
			rd_ack_o <= 1'b0;

			if (erase_start_i && (erase_state == ERASE_IDLE)) begin
				erase_state <= ERASE_RUN;
				erase_addr <= '0;
			end

			if (slot_fall) begin
				case (op_sel)
					MEM_LOAD_WR: begin
						mem_ce_o <= 1'b1;
						wr_ack_o <= 1'b1;
					end
					MEM_ERASE_WR: begin
						mem_ce_o <= 1'b1;
						if (erase_addr == addr_t'(`ERASE_TOP))
							erase_state <= ERASE_IDLE;
						else
							erase_addr <= erase_addr + 1'b1;
					end
					MEM_TAP_RD: begin
						mem_ce_o <= 1'b1;
						rd_ack_o <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// ============================================================
	// Memory address and data
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (slot_fall) begin
			case (op_sel)
				MEM_LOAD_WR: begin
					mem_we_o <= 1'b1;
					mem_addr_o <= wr_addr_i;
					mem_wdata_o <= wr_data_i;
				end
				MEM_ERASE_WR: begin
					mem_we_o <= 1'b1;
					mem_addr_o <= erase_addr;
					// Alternating 64-byte blocks of 00 and FF
					mem_wdata_o <= {`DATA_W{erase_addr[6]}};
				end
				MEM_TAP_RD: begin
					mem_we_o <= 1'b0;
					mem_addr_o <= rd_addr_i;
				end
				default: ;
			endcase
		end
	end

endmodule

/* logic/tape_feed.sv */
`timescale 1ns/100ps
`include "loader_settings.svh"

module tape_feed import loader_pkg::*; (
	input  logic  clk_sys,
	input  logic  reset_n,
	input  logic  tap_done_i,
	input  addr_t tap_len_i,
	input  logic  tap_toggle_i,
	input  logic  rd_ack_i,
	input  byte_t mem_rdata_i,
	output logic  rd_req_o,
	output addr_t rd_addr_o,
	output byte_t tap_byte_o,
	output logic  tap_wr_o,
	output logic  tap_playing_o
);

	addr_t len_q;
	addr_t play_off;
	logic  fetch_q;
	logic  at_end;

	assign rd_addr_o = `TAP_BASE + play_off;
	assign at_end    = play_off >= len_q;

	// ============================================================
	// Play control and read requests
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			len_q <= '0;
			play_off <= '0;
			fetch_q <= 1'b0;
			rd_req_o <= 1'b0;
			tap_wr_o <= 1'b0;
			tap_playing_o <= 1'b0;
		end else begin
			// Read data is valid the cycle after the acknowledge
			fetch_q <= rd_ack_i;
			tap_wr_o <= fetch_q;

			if (tap_done_i) begin
				len_q <= tap_len_i;
				play_off <= '0;
				rd_req_o <= 1'b0;
				tap_playing_o <= 1'b1;
			end else begin
				if (rd_ack_i) begin
					rd_req_o <= 1'b0;
					play_off <= play_off + 1'b1;
				end else if (tap_playing_o && !rd_req_o && !at_end) begin
					rd_req_o <= 1'b1;
				end

				if (tap_toggle_i)
					tap_playing_o <= ~tap_playing_o;
				// Stop once the last byte has gone out
				else if (tap_playing_o && at_end && !rd_req_o && !fetch_q && !tap_wr_o)
					tap_playing_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fetch_q)
			tap_byte_o <= mem_rdata_i;
	end

endmodule

/* logic/c64_loader_top.sv */
`timescale 1ns/100ps
`include "loader_settings.svh"

module c64_loader_top import loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset_n,
	// Host download stream
	input  logic        dl_active_i,
	input  byte_t       dl_index_i,
	input  logic        dl_wr_i,
	input  addr_t       dl_addr_i,
	input  byte_t       dl_data_i,
	output logic        dl_wait_o,
	// Memory slot and byte memory
	input  logic        slot_i,
	output logic        mem_ce_o,
	output logic        mem_we_o,
	output addr_t       mem_addr_o,
	output byte_t       mem_wdata_o,
	input  byte_t       mem_rdata_i,
	// Control
	input  logic        erase_start_i,
	output logic        erasing_o,
	input  logic        tap_toggle_i,
	input  logic        detach_i,
	// Tape FIFO
	input  logic        tap_full_i,
	output byte_t       tap_byte_o,
	output logic        tap_wr_o,
	output logic        tap_playing_o,
	// Cartridge
	output logic [15:0] cart_id_o,
	output byte_t       cart_exrom_o,
	output byte_t       cart_game_o,
	output logic [15:0] bank_num_o,
	output logic [15:0] bank_laddr_o,
	output logic [15:0] bank_size_o,
	output logic        bank_wr_o,
	output logic        cart_attached_o
);

	logic  wr_req;
	addr_t wr_addr;
	byte_t wr_data;
	logic  wr_ack;
	logic  rd_req;
	addr_t rd_addr;
	logic  rd_ack;
	addr_t tap_len;
	logic  tap_done;

	// Host waits while a write is still looking for a slot
	assign dl_wait_o = wr_req;

	load_decode u_decode (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.detach_i        (detach_i),
		.wr_ack_i        (wr_ack),
		.wr_req_o        (wr_req),
		.wr_addr_o       (wr_addr),
		.wr_data_o       (wr_data),
		.tap_len_o       (tap_len),
		.tap_done_o      (tap_done),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.bank_wr_o       (bank_wr_o),
		.cart_attached_o (cart_attached_o)
	);

	slot_sequencer u_seq (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.slot_i        (slot_i),
		.wr_req_i      (wr_req),
		.wr_addr_i     (wr_addr),
		.wr_data_i     (wr_data),
		.wr_ack_o      (wr_ack),
		.rd_req_i      (rd_req),
		.rd_addr_i     (rd_addr),
		.rd_ack_o      (rd_ack),
		.tap_full_i    (tap_full_i),
		.erase_start_i (erase_start_i),
		.erasing_o     (erasing_o),
		.mem_ce_o      (mem_ce_o),
		.mem_we_o      (mem_we_o),
		.mem_addr_o    (mem_addr_o),
		.mem_wdata_o   (mem_wdata_o)
	);

	tape_feed u_tape (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.tap_done_i    (tap_done),
		.tap_len_i     (tap_len),
		.tap_toggle_i  (tap_toggle_i),
		.rd_ack_i      (rd_ack),
		.mem_rdata_i   (mem_rdata_i),
		.rd_req_o      (rd_req),
		.rd_addr_o     (rd_addr),
		.tap_byte_o    (tap_byte_o),
		.tap_wr_o      (tap_wr_o),
		.tap_playing_o (tap_playing_o)
	);

endmodule

/* tests/tb_c64_loader.sv */
`timescale 1ns/100ps
`include "loader_settings.svh"

module tb_c64_loader import loader_pkg::*; ();

	// ============================================================
	// Run length
	// ============================================================

	localparam int SLOT_PERIOD = 8;
	// Bytes sent by the host over all downloads
	localparam int HOST_BYTES  = 22 + 130 + 30 + 16;
	// Each host byte may cost a write slot, a playback read and a stalled slot
	localparam int MAX_CYCLES  = (`ERASE_TOP + 1 + 4 * HOST_BYTES + 64) * SLOT_PERIOD;

	// DUT inputs start from known values
	logic        clk_sys = 1'b0;
	logic        reset_n = 1'b0;
	logic        dl_active_i = 1'b0;
	byte_t       dl_index_i = '0;
	logic        dl_wr_i = 1'b0;
	addr_t       dl_addr_i = '0;
	byte_t       dl_data_i = '0;
	logic        slot_i = 1'b0;
	byte_t       mem_rdata_i = '0;
	logic        erase_start_i = 1'b0;
	logic        tap_toggle_i = 1'b0;
	logic        detach_i = 1'b0;
	logic        tap_full_i = 1'b0;

	// DUT outputs
	logic        dl_wait_o;
	logic        mem_ce_o;
	logic        mem_we_o;
	addr_t       mem_addr_o;
	byte_t       mem_wdata_o;
	logic        erasing_o;
	byte_t       tap_byte_o;
	logic        tap_wr_o;
	logic        tap_playing_o;
	logic [15:0] cart_id_o;
	byte_t       cart_exrom_o;
	byte_t       cart_game_o;
	logic [15:0] bank_num_o;
	logic [15:0] bank_laddr_o;
	logic [15:0] bank_size_o;
	logic        bank_wr_o;
	logic        cart_attached_o;

	// Stimulus file and what it should leave behind
	byte_t       file_buf [0:255];
	logic        is_wr [0:255];
	int          file_len;
	addr_t       exp_addr [0:255];
	byte_t       exp_data [0:255];
	int          exp_n;
	addr_t       run_addr;
	logic [15:0] exp_bank_num [0:3];
	logic [15:0] exp_bank_laddr [0:3];
	logic [15:0] exp_bank_size [0:3];
	int          chip_n;
	byte_t       tape_exp [0:63];
	int          tape_n;

	// Byte memory model
	byte_t       mem [addr_t];

	logic        cur_is_wr = 1'b0;
	logic        pending = 1'b0;
	logic        full_rand_en = 1'b0;
	logic        erase_check = 1'b0;
	logic [2:0]  slot_cnt = '0;
	logic [15:0] lfsr_q = 16'd54;
	int          tap_seen = 0;
	int          bank_seen = 0;
	int          erase_seen = 0;
	int          cycle_count = 0;
	int          error_count = 0;
	int          test_err_base = 0;
	int          test_num = 1;
	int          tests_failed = 0;

	c64_loader_top UUT (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_wait_o       (dl_wait_o),
		.slot_i          (slot_i),
		.mem_ce_o        (mem_ce_o),
		.mem_we_o        (mem_we_o),
		.mem_addr_o      (mem_addr_o),
		.mem_wdata_o     (mem_wdata_o),
		.mem_rdata_i     (mem_rdata_i),
		.erase_start_i   (erase_start_i),
		.erasing_o       (erasing_o),
		.tap_toggle_i    (tap_toggle_i),
		.detach_i        (detach_i),
		.tap_full_i      (tap_full_i),
		.tap_byte_o      (tap_byte_o),
		.tap_wr_o        (tap_wr_o),
		.tap_playing_o   (tap_playing_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.bank_wr_o       (bank_wr_o),
		.cart_attached_o (cart_attached_o)
	);

	initial begin
		forever #10 clk_sys = ~clk_sys;
	end

	// Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic [7:0] lfsr_take(input int nbits);
		logic [7:0] val;
		logic       fb;
		int         i;
		val = '0;
		for (i = 0; i < nbits; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			val = {val[6:0], fb};
		end
		return val;
	endfunction

	// Unwritten memory reads back a byte folded from every address bit
	function automatic byte_t fill_byte(input addr_t a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]} ^ 8'hC3;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		error_count++;
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		error_count++;
	endtask

	// ============================================================
	// Slots, tape FIFO, memory model and watchdog
	// ============================================================

	always @(posedge clk_sys) begin
		slot_cnt <= slot_cnt + 3'd1;
		slot_i <= (slot_cnt == 3'd7);
		// FIFO full about a quarter of the time
		if (full_rand_en)
			tap_full_i <= (lfsr_take(2) == 8'd3);
		else
			tap_full_i <= 1'b0;
	end

	// Read data comes back on the cycle after the strobe
	always @(posedge clk_sys) begin
		if (mem_ce_o && mem_we_o)
			mem[mem_addr_o] = mem_wdata_o;
		if (mem_ce_o && !mem_we_o)
			mem_rdata_i <= mem.exists(mem_addr_o) ? mem[mem_addr_o] : fill_byte(mem_addr_o);
	end

	// Host write still waiting for its slot
	always @(posedge clk_sys) begin
		if (!reset_n)
			pending <= 1'b0;
		else if (dl_wr_i && cur_is_wr)
			pending <= 1'b1;
		else if (mem_ce_o && mem_we_o)
			pending <= 1'b0;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, a test never finished", cycle_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ============================================================
	// Checks
	// ============================================================

	assert property (@(posedge clk_sys) disable iff (!reset_n) dl_wait_o == pending)
		else report_mismatch("dl_wait_o does not match the pending host write");

	assert property (@(posedge clk_sys) disable iff (!reset_n)
		(mem_ce_o && !mem_we_o) |-> !$past(tap_full_i))
		else report_error("tape read strobe issued while the tape FIFO was full");

	assert property (@(posedge clk_sys) disable iff (!reset_n)
		($fell(dl_active_i) && dl_index_i == 8'd5) |=> cart_attached_o)
		else report_mismatch("cart_attached_o did not rise at the end of the CRT download");

	assert property (@(posedge clk_sys) disable iff (!reset_n) detach_i |=> !cart_attached_o)
		else report_mismatch("cart_attached_o still high after detach_i");

	always @(negedge clk_sys) begin
		if (tap_wr_o) begin
			if (tap_seen >= tape_n)
				report_error("tape byte delivered beyond the end of the tape");
			else
				assert (tap_byte_o == tape_exp[tap_seen])
					else report_mismatch($sformatf("tape byte %0d is %h, expected %h",
						tap_seen, tap_byte_o, tape_exp[tap_seen]));
			tap_seen <= tap_seen + 1;
		end
		if (bank_wr_o) begin
			if (bank_seen >= chip_n)
				report_error("bank_wr_o pulsed more often than there are chip packets");
			else
				assert (bank_num_o == exp_bank_num[bank_seen] &&
					bank_laddr_o == exp_bank_laddr[bank_seen] &&
					bank_size_o == exp_bank_size[bank_seen])
					else report_mismatch($sformatf("bank %0d header is %h %h %h", bank_seen,
						bank_num_o, bank_laddr_o, bank_size_o));
			bank_seen <= bank_seen + 1;
		end
		if (erase_check && mem_ce_o && mem_we_o) begin
			assert (mem_addr_o == addr_t'(erase_seen) &&
				mem_wdata_o == (((erase_seen % 128) >= 64) ? 8'hFF : 8'h00))
				else report_mismatch($sformatf("erase wrote %h to %h, step %0d",
					mem_wdata_o, mem_addr_o, erase_seen));
			erase_seen <= erase_seen + 1;
		end
	end

	// ============================================================
	// Stimulus helpers
	// ============================================================

	task automatic new_file();
		file_len = 0;
		exp_n = 0;
		chip_n = 0;
		mem.delete();
	endtask

	task automatic put_byte(input byte_t b, input logic wr);
		file_buf[file_len] = b;
		is_wr[file_len] = wr;
		file_len++;
	endtask

	task automatic expect_write(input addr_t a, input byte_t d);
		exp_addr[exp_n] = a;
		exp_data[exp_n] = d;
		exp_n++;
	endtask

	// One CRT chip packet whose data starts on the next 8 KB boundary
	task automatic add_chip(input logic [15:0] bank, input logic [15:0] laddr, input int n);
		logic [31:0] len;
		byte_t       b;
		int          i;
		len = 32'(n + `CHIP_HDR_LEN);
		put_byte(8'h43, 1'b0);
		put_byte(8'h48, 1'b0);
		put_byte(8'h49, 1'b0);
		put_byte(8'h50, 1'b0);
		for (i = 0; i < 4; i++)
			put_byte(len[31 - 8 * i -: 8], 1'b0);
		put_byte(8'h00, 1'b0);
		put_byte(8'h00, 1'b0);
		put_byte(bank[15:8], 1'b0);
		put_byte(bank[7:0], 1'b0);
		put_byte(laddr[15:8], 1'b0);
		put_byte(laddr[7:0], 1'b0);
		put_byte(8'(n >> 8), 1'b0);
		put_byte(8'(n), 1'b0);
		run_addr = addr_t'(((int'(run_addr) + 8191) / 8192) * 8192);
		for (i = 0; i < n; i++) begin
			b = 8'(i * 5 + int'(bank) * 40 + 1);
			put_byte(b, 1'b1);
			expect_write(run_addr, b);
			run_addr = run_addr + addr_t'(1);
		end
		exp_bank_num[chip_n] = bank;
		exp_bank_laddr[chip_n] = laddr;
		exp_bank_size[chip_n] = 16'(n);
		chip_n++;
	endtask

	task automatic build_tape(input int n, input int mult);
		byte_t b;
		int    i;
		new_file();
		for (i = 0; i < n; i++) begin
			b = 8'(i * mult + 3) ^ 8'h5A;
			put_byte(b, 1'b1);
			expect_write(addr_t'(`TAP_BASE + i), b);
			tape_exp[i] = b;
		end
		tape_n = n;
	endtask

	// Host sends one strobe per byte and holds off while dl_wait_o is high
	task automatic run_download(input byte_t index);
		int i;
		@(posedge clk_sys);
		dl_index_i <= index;
		dl_active_i <= 1'b1;
		for (i = 0; i < file_len; i++) begin
			@(negedge clk_sys);
			while (dl_wait_o)
				@(negedge clk_sys);
			@(posedge clk_sys);
			dl_wr_i <= 1'b1;
			cur_is_wr <= is_wr[i];
			dl_addr_i <= addr_t'(i);
			dl_data_i <= file_buf[i];
			@(posedge clk_sys);
			dl_wr_i <= 1'b0;
		end
		@(negedge clk_sys);
		while (dl_wait_o)
			@(negedge clk_sys);
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic check_memory(input string what);
		int i;
		assert (mem.num() == exp_n)
			else report_mismatch($sformatf("%s left %0d bytes, expected %0d",
				what, mem.num(), exp_n));
		for (i = 0; i < exp_n; i++)
			assert (mem.exists(exp_addr[i]) && mem[exp_addr[i]] == exp_data[i])
				else report_mismatch($sformatf("%s byte at %h is wrong, expected %h",
					what, exp_addr[i], exp_data[i]));
	endtask

	task automatic end_test(input string name);
		if (error_count == test_err_base) begin
			$display("Test %0d %s: passed", test_num, name);
		end else begin
			$display("Test %0d %s: failed with %0d errors", test_num, name,
				error_count - test_err_base);
			tests_failed++;
		end
		test_num++;
		test_err_base = error_count;
	endtask

	task automatic play_and_wait();
		while (!tap_playing_o)
			@(negedge clk_sys);
		while (tap_playing_o)
			@(negedge clk_sys);
	endtask

	task automatic pulse_toggle();
		@(posedge clk_sys);
		tap_toggle_i <= 1'b1;
		@(posedge clk_sys);
		tap_toggle_i <= 1'b0;
		@(negedge clk_sys);
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		int    i;
		int    prg_base;
		int    paused_count;
		byte_t b;

		repeat (4) @(posedge clk_sys);
		reset_n <= 1'b1;

		@(negedge clk_sys);
		assert (!mem_ce_o && !dl_wait_o && !tap_wr_o && !bank_wr_o &&
			!cart_attached_o && !tap_playing_o && !erasing_o)
			else report_mismatch("an output is not low after reset");
		end_test("reset state");

		// PRG with the load address first
		new_file();
		put_byte(8'h00, 1'b0);
		put_byte(8'hC0, 1'b0);
		prg_base = int'(file_buf[1]) * 256 + int'(file_buf[0]);
		for (i = 0; i < 20; i++) begin
			b = 8'(i * 13 + 7);
			put_byte(b, 1'b1);
			expect_write(addr_t'(prg_base + i), b);
		end
		run_download(8'd4);
		@(negedge clk_sys);
		check_memory("PRG");
		end_test("PRG load");

		// CRT with a file header and two chip packets
		new_file();
		for (i = 0; i < `CRT_CHIP_START; i++)
			put_byte(8'h20, 1'b0);
		file_buf[`CRT_HDR_ID] = 8'h00;
		file_buf[`CRT_HDR_ID + 1] = 8'h13;
		file_buf[`CRT_HDR_ID + 2] = 8'h01;
		file_buf[`CRT_HDR_ID + 3] = 8'h00;
		run_addr = `CRT_BASE;
		add_chip(16'd0, 16'h8000, 24);
		add_chip(16'd1, 16'hA000, 10);
		run_download(8'd5);
		@(negedge clk_sys);
		check_memory("CRT");
		assert (cart_id_o == 16'h0013 && cart_exrom_o == 8'h01 && cart_game_o == 8'h00)
			else report_mismatch($sformatf("cartridge header is %h %h %h",
				cart_id_o, cart_exrom_o, cart_game_o));
		assert (bank_seen == chip_n)
			else report_mismatch($sformatf("%0d bank_wr_o pulses, expected %0d",
				bank_seen, chip_n));
		assert (cart_attached_o)
			else report_mismatch("cart_attached_o low after the CRT download");
		@(posedge clk_sys);
		detach_i <= 1'b1;
		@(posedge clk_sys);
		detach_i <= 1'b0;
		@(negedge clk_sys);
		assert (!cart_attached_o)
			else report_mismatch("cart_attached_o high after detach");
		end_test("CRT load");

		// TAP with the FIFO pushing back
		build_tape(30, 11);
		@(negedge clk_sys);
		full_rand_en = 1'b1;
		run_download(8'd6);
		play_and_wait();
		full_rand_en = 1'b0;
		@(negedge clk_sys);
		check_memory("TAP");
		assert (tap_seen == tape_n)
			else report_mismatch($sformatf("%0d tape bytes played, expected %0d",
				tap_seen, tape_n));
		end_test("TAP playback");

		// Pause after a few bytes, then resume
		build_tape(16, 7);
		tap_seen = 0;
		run_download(8'd6);
		while (tap_seen < 5)
			@(negedge clk_sys);
		pulse_toggle();
		assert (!tap_playing_o)
			else report_mismatch("tap_playing_o still high after the first toggle");
		// Let a read already granted drain
		repeat (3 * SLOT_PERIOD) @(negedge clk_sys);
		paused_count = tap_seen;
		repeat (6 * SLOT_PERIOD) @(negedge clk_sys);
		assert (tap_seen == paused_count && tap_seen < tape_n)
			else report_mismatch($sformatf("tape kept playing while paused, %0d then %0d",
				paused_count, tap_seen));
		pulse_toggle();
		while (tap_playing_o)
			@(negedge clk_sys);
		@(negedge clk_sys);
		assert (tap_seen == tape_n)
			else report_mismatch($sformatf("%0d tape bytes after resume, expected %0d",
				tap_seen, tape_n));
		end_test("TAP pause and resume");

		// Erase the low 64 KB
		mem.delete();
		erase_check = 1'b1;
		@(posedge clk_sys);
		erase_start_i <= 1'b1;
		@(posedge clk_sys);
		erase_start_i <= 1'b0;
		while (!erasing_o)
			@(negedge clk_sys);
		while (erasing_o)
			@(negedge clk_sys);
		@(negedge clk_sys);
		erase_check = 1'b0;
		assert (erase_seen == `ERASE_TOP + 1)
			else report_mismatch($sformatf("erase wrote %0d bytes, expected %0d",
				erase_seen, `ERASE_TOP + 1));
		end_test("memory erase");

		$display("Summary: %0d tests, %0d failed, %0d errors",
			test_num - 1, tests_failed, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+include
logic/loader_pkg.sv
logic/mem_pkg.sv
logic/load_decode.sv
logic/slot_sequencer.sv
logic/tape_feed.sv
logic/c64_loader_top.sv
tests/tb_c64_loader.sv

/* Makefile */
# Verilator build and run for the download loader testbench

VERILATOR ?= verilator
TOP       ?= tb_c64_loader
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
